//--- dbg_spr_top.f
+incdir+rtl
rtl/dbg_spr_pkg.sv
rtl/dbg_spr_ifs.sv
rtl/dbg_burst_ctrl.sv
rtl/dbg_spr_bridge.sv
rtl/spr_bank.sv
rtl/dbg_spr_top.sv
testbench/dbg_spr_tb.sv

//--- run.sh
#!/bin/sh
# Build the debug SPR testbench with Verilator, run it and look for the pass line
rm -rf obj_dir sim.log

verilator --binary --timing --top-module dbg_spr_tb -f dbg_spr_top.f -o dbg_spr_sim \
  && ./obj_dir/dbg_spr_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q '^>>> PASS$' sim.log \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

//--- testbench/dbg_spr_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the debug SPR path with tck and cpu_clk clocks
// LCG stimulus, bank model, burst tests and watchdog
////////////////////////////////////////////////////////////////////////////

`include "dbg_spr_cfg.svh"

module dbg_spr_tb;

  import dbg_spr_pkg::*;

  // Input drive delay after the tck edge
  localparam int DRV = 2;
  localparam int MIX_BURSTS = 24;
  // Upper bound on words over all tests
  localparam int TOTAL_WORDS = 16 + 16 + 24 + 12 + 10 + MIX_BURSTS * 8;
  localparam int WATCH_CYCLES = TOTAL_WORDS * 60;

  logic                    tck_i;
  logic                    cpu_clk_i;
  logic                    rst_i;
  logic                    cmd_start_i;
  dbg_op_e                 cmd_op_i;
  logic [`DBG_ADDR_W-1:0]  cmd_addr_i;
  logic [`BURST_CNT_W-1:0] cmd_count_i;
  logic [`DBG_DATA_W-1:0]  wdata_i;
  logic                    busy_o;
  logic                    word_done_o;
  logic [`DBG_DATA_W-1:0]  rdata_o;

  // Bank contents as expected from the writes so far
  logic [`DBG_DATA_W-1:0]  model_q [`SPR_DEPTH];
  logic [31:0]             rng_q = 32'hcd23;
  string                   test_name = "reset";

  dbg_spr_top dut (
    .tck_i       (tck_i),
    .cpu_clk_i   (cpu_clk_i),
    .rst_i       (rst_i),
    .cmd_start_i (cmd_start_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_count_i (cmd_count_i),
    .wdata_i     (wdata_i),
    .busy_o      (busy_o),
    .word_done_o (word_done_o),
    .rdata_o     (rdata_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clocks and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    cpu_clk_i = 1'b0;
    forever #10 cpu_clk_i = ~cpu_clk_i;
  end

  // Unrelated tck period so the crossing sees every phase
  initial begin
    tck_i = 1'b0;
    forever #23 tck_i = ~tck_i;
  end

  initial begin
    repeat (WATCH_CYCLES) @(posedge tck_i);
    abort_run("watchdog timeout: a burst did not finish in time");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (exp === act) else begin
      abort_run($sformatf("mismatch %s %s expected 0x%h actual 0x%h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic require_cond(input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      abort_run($sformatf("%s: %s", test_name, msg));
    end
  endtask

  // Numerical Recipes LCG constants
  function automatic logic [31:0] next_rand();
    rng_q = rng_q * 32'd1664525 + 32'd1013904223;
    return rng_q;
  endfunction

  // One burst from command to busy_o falling
  // Writes update the model per word, reads are checked against it
  task automatic run_burst(input dbg_op_e op, input logic [`DBG_ADDR_W-1:0] addr,
                           input logic [`BURST_CNT_W-1:0] count, input bit poke_busy);
    logic [`DBG_DATA_W-1:0] wd [$];
    int unsigned            n;
    int unsigned            seen;
    int unsigned            widx;
    bit                     first;
    logic                   running;
    n = (count == '0) ? 1 : int'(count);
    for (int i = 0; i < int'(n); i++) begin
      wd.push_back(next_rand());
    end
    @(posedge tck_i);
    #DRV;
    cmd_start_i = 1'b1;
    cmd_op_i    = op;
    cmd_addr_i  = addr;
    cmd_count_i = count;
    // First word data must be there for the first strobe
    wdata_i     = wd[0];
    @(posedge tck_i);
    #DRV;
    cmd_start_i = 1'b0;
    seen  = 0;
    first = 1'b1;
    do begin
      // Outputs are all tck registered, stable at the falling edge
      @(negedge tck_i);
      if (first) begin
        require_cond(busy_o, "busy_o did not rise after the command");
      end
      if (word_done_o) begin
        require_cond(seen < n, "more word_done_o pulses than words in the burst");
        widx = (addr + seen) % `SPR_DEPTH;
        if (op == OP_BURST_WRITE) begin
          model_q[widx] = wd[seen];
        end else begin
          compare_word($sformatf("rdata word %0d", seen), model_q[widx], rdata_o);
        end
        seen++;
      end
      running = busy_o;
      @(posedge tck_i);
      #DRV;
      // Next word data ahead of its strobe
      if (seen < n) begin
        wdata_i = wd[seen];
      end
      if (poke_busy && first) begin
        // Conflicting command while busy, must be ignored
        cmd_start_i = 1'b1;
        cmd_op_i    = (op == OP_BURST_READ) ? OP_BURST_WRITE : OP_BURST_READ;
        cmd_addr_i  = next_rand();
        cmd_count_i = 8'd1;
      end else begin
        cmd_start_i = 1'b0;
      end
      first = 1'b0;
    end while (running);
    compare_word("word_done_o count", n, seen);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]             base;
    logic [31:0]             r;
    logic [`BURST_CNT_W-1:0] cnt;
    rst_i       = 1'b1;
    cmd_start_i = 1'b0;
    cmd_op_i    = OP_BURST_READ;
    cmd_addr_i  = '0;
    cmd_count_i = '0;
    wdata_i     = '0;
    for (int i = 0; i < `SPR_DEPTH; i++) begin
      model_q[i] = '0;
    end
    repeat (4) @(posedge cpu_clk_i);
    #DRV;
    rst_i = 1'b0;
    repeat (2) @(negedge tck_i);
    require_cond(!busy_o, "busy_o high after reset");

    // Whole bank reads zero
    run_burst(OP_BURST_READ, 32'h0, 8'(`SPR_DEPTH), 1'b0);

    test_name = "write_read";
    base = next_rand();
    run_burst(OP_BURST_WRITE, base, 8'd8, 1'b0);
    run_burst(OP_BURST_READ, base, 8'd8, 1'b0);

    // Every low address pair, so zero to three wait states on the first word
    test_name = "wait_states";
    for (int w = 0; w < 4; w++) begin
      base = (next_rand() & ~32'h3) | 32'(w);
      run_burst(OP_BURST_WRITE, base, 8'd3, 1'b0);
      run_burst(OP_BURST_READ, base, 8'd3, 1'b0);
    end

    // Crosses the last index, read back through other upper bits
    test_name = "addr_wrap";
    base = (next_rand() & ~32'hf) | 32'(`SPR_DEPTH - 3);
    run_burst(OP_BURST_WRITE, base, 8'd6, 1'b0);
    run_burst(OP_BURST_READ, base ^ 32'h0100_0000, 8'd6, 1'b0);

    test_name = "cmd_while_busy";
    base = next_rand();
    run_burst(OP_BURST_WRITE, base, 8'd5, 1'b1);
    run_burst(OP_BURST_READ, base, 8'd5, 1'b1);

    // Counts 0 to 8, zero runs one word
    test_name = "random_mix";
    for (int b = 0; b < MIX_BURSTS; b++) begin
      r   = next_rand() % 32'd9;
      cnt = r[`BURST_CNT_W-1:0];
      run_burst(next_rand() % 32'd2 == 32'd0 ? OP_BURST_READ : OP_BURST_WRITE,
                next_rand(), cnt, 1'b0);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- rtl/dbg_spr_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the debug SPR path
// Burst controller, clock crossing bridge and SPR bank
////////////////////////////////////////////////////////////////////////////

`include "dbg_spr_cfg.svh"

module dbg_spr_top (
  // Clocks and reset
  input  logic                    tck_i,
  input  logic                    cpu_clk_i,
  input  logic                    rst_i,
  // Burst command in the tck domain
  input  logic                    cmd_start_i,
  input  dbg_spr_pkg::dbg_op_e    cmd_op_i,
  input  logic [`DBG_ADDR_W-1:0]  cmd_addr_i,
  input  logic [`BURST_CNT_W-1:0] cmd_count_i,
  input  logic [`DBG_DATA_W-1:0]  wdata_i,
  // Burst status in the tck domain
  output logic                    busy_o,
  output logic                    word_done_o,
  output logic [`DBG_DATA_W-1:0]  rdata_o
);

  // Word access link in the tck domain
  dbg_req_if req_if ();

  // SPR bus in the cpu_clk domain
  spr_bus_if bus_if ();

  // Producer
  dbg_burst_ctrl u_burst_ctrl (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .cmd_start_i (cmd_start_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_count_i (cmd_count_i),
    .wdata_i     (wdata_i),
    .busy_o      (busy_o),
    .word_done_o (word_done_o),
    .rdata_o     (rdata_o),
    .req         (req_if.master)
  );

  // Clock crossing
  dbg_spr_bridge u_bridge (
    .tck_i     (tck_i),
    .cpu_clk_i (cpu_clk_i),
    .rst_i     (rst_i),
    .req       (req_if.slave),
    .bus       (bus_if.master)
  );

  // Consumer
  spr_bank #(
    .DEPTH (`SPR_DEPTH)
  ) u_spr_bank (
    .cpu_clk_i (cpu_clk_i),
    .rst_i     (rst_i),
    .bus       (bus_if.slave)
  );

endmodule

//--- rtl/spr_bank.sv
////////////////////////////////////////////////////////////////////////////
// SPR register file with wait states set by the low two address bits
////////////////////////////////////////////////////////////////////////////

`include "dbg_spr_cfg.svh"

module spr_bank #(
  // Power of two
  parameter int DEPTH = `SPR_DEPTH
) (
  input  logic     cpu_clk_i,
  input  logic     rst_i,
  spr_bus_if.slave bus
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [`DBG_DATA_W-1:0] mem_q [DEPTH];
  // Word index wraps modulo DEPTH
  logic [IDX_W-1:0]       idx;
  // stb cycles seen so far in this access
  logic [1:0]             wait_q;
  logic                   hit;

  assign idx = bus.addr[IDX_W-1:0];

  // Ack once the wait count reaches the low address bits
  // Zero wait states acks in the first stb cycle
  assign hit       = bus.stb && (wait_q == bus.addr[1:0]);
  assign bus.ack   = hit;
  assign bus.rdata = mem_q[idx];

  ////////////////////////////////////////////////////////////////////////////
  // Wait state counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wait_q <= 2'd0;
    end else if (hit) begin
      wait_q <= 2'd0;
    end else if (bus.stb) begin
      wait_q <= wait_q + 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register array
  ////////////////////////////////////////////////////////////////////////////

  // All words come out of reset as zero
  // Write lands at the edge that ends the ack cycle
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (hit && bus.we) begin
      mem_q[idx] <= bus.wdata;
    end
  end

endmodule

//--- rtl/dbg_spr_bridge.sv
////////////////////////////////////////////////////////////////////////////
// Clock domain crossing bridge from tck debug strobes to SPR bus accesses
// Toggle synchronizers carry start and ready between the two clocks
////////////////////////////////////////////////////////////////////////////

`include "dbg_spr_cfg.svh"

module dbg_spr_bridge (
  input  logic      tck_i,
  input  logic      cpu_clk_i,
  input  logic      rst_i,
  dbg_req_if.slave  req,
  spr_bus_if.master bus
);

  import dbg_spr_pkg::*;

  // tck domain
  logic                   rdy_q;
  logic                   accept;
  // Start flag toggles once per accepted access
  logic                   start_tgl_q;
  logic [`DBG_ADDR_W-1:0] addr_q;
  logic [`DBG_DATA_W-1:0] wdata_q;
  logic                   we_q;
  // Done flag synchronizer
  logic                   done_ff1_q;
  logic                   done_ff2_q;
  logic                   done_ff3_q;

  // cpu_clk domain
  logic                   start_ff1_q;
  logic                   start_ff2_q;
  logic                   start_ff3_q;
  logic                   start_pulse;
  bridge_state_e          state_q;
  bridge_state_e          state_d;
  logic                   finish;
  logic                   done_tgl_q;
  logic [`DBG_DATA_W-1:0] rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Debug clock side
  ////////////////////////////////////////////////////////////////////////////

  assign accept = req.strobe && rdy_q;

  // Request payload
  // Held stable until the next accept so the cpu side can use it directly
  always_ff @(posedge tck_i) begin
    if (accept) begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
      we_q    <= ~req.rd_wrn;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      start_tgl_q <= 1'b0;
      done_ff1_q  <= 1'b0;
      done_ff2_q  <= 1'b0;
      done_ff3_q  <= 1'b0;
      rdy_q       <= 1'b1;
    end else begin
      done_ff1_q <= done_tgl_q;
      done_ff2_q <= done_ff1_q;
      done_ff3_q <= done_ff2_q;
      if (accept) begin
        start_tgl_q <= ~start_tgl_q;
        rdy_q       <= 1'b0;
      end else if (done_ff2_q != done_ff3_q) begin
        // Done toggle arrived so the access is over
        rdy_q <= 1'b1;
      end
    end
  end

  assign req.rdy   = rdy_q;
  assign req.rdata = rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // CPU clock side
  ////////////////////////////////////////////////////////////////////////////

  // Two flop synchronizer plus one flop for edge detect
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      start_ff1_q <= 1'b0;
      start_ff2_q <= 1'b0;
      start_ff3_q <= 1'b0;
    end else begin
      start_ff1_q <= start_tgl_q;
      start_ff2_q <= start_ff1_q;
      start_ff3_q <= start_ff2_q;
    end
  end

  assign start_pulse = start_ff2_q ^ start_ff3_q;

  // stb in the start cycle and through the whole transfer
  assign bus.stb   = start_pulse || (state_q == ST_TRANSFER);
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.we    = we_q;

  // Single-cycle ack never leaves ST_IDLE
  always_comb begin
    state_d = state_q;
    finish  = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (start_pulse) begin
          finish = bus.ack;
          if (!bus.ack) begin
            state_d = ST_TRANSFER;
          end
        end
      end
      ST_TRANSFER: begin
        finish = bus.ack;
        if (bus.ack) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      done_tgl_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (finish) begin
        done_tgl_q <= ~done_tgl_q;
      end
    end
  end

  // Read data captured in the ack cycle
  always_ff @(posedge cpu_clk_i) begin
    if (finish && !we_q) begin
      rdata_q <= bus.rdata;
    end
  end

endmodule

//--- rtl/dbg_burst_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Burst sequencer in the tck domain
// Splits burst read and write commands into single word accesses
////////////////////////////////////////////////////////////////////////////

`include "dbg_spr_cfg.svh"

module dbg_burst_ctrl (
  input  logic                    tck_i,
  input  logic                    rst_i,
  // Burst command
  input  logic                    cmd_start_i,
  input  dbg_spr_pkg::dbg_op_e    cmd_op_i,
  input  logic [`DBG_ADDR_W-1:0]  cmd_addr_i,
  input  logic [`BURST_CNT_W-1:0] cmd_count_i,
  input  logic [`DBG_DATA_W-1:0]  wdata_i,
  // Burst status
  output logic                    busy_o,
  output logic                    word_done_o,
  output logic [`DBG_DATA_W-1:0]  rdata_o,
  // Word accesses toward the bridge
  dbg_req_if.master               req
);

  import dbg_spr_pkg::*;

  localparam logic [`BURST_CNT_W-1:0] CNT_ONE  = 1;
  localparam logic [`DBG_ADDR_W-1:0]  ADDR_ONE = 1;

  burst_state_e              state_q;
  burst_state_e              state_d;
  dbg_op_e                   op_q;
  // Address of the word in flight
  logic [`DBG_ADDR_W-1:0]    addr_q;
  // Words still to go including the current one
  logic [`BURST_CNT_W-1:0]   cnt_q;
  logic                      start_ok;
  logic                      issue;
  logic                      done;
  logic                      last_word;

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////////////////////

  // New commands only taken while idle
  assign start_ok  = cmd_start_i && (state_q == BS_IDLE);
  // Strobe only goes out while the bridge is ready
  assign issue     = (state_q == BS_ISSUE) && req.rdy;
  // rdy back high in BS_WAIT ends the current word
  assign done      = (state_q == BS_WAIT) && req.rdy;
  assign last_word = (cnt_q == CNT_ONE);

  ////////////////////////////////////////////////////////////////////////////
  // Burst FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      BS_IDLE: begin
        if (start_ok) begin
          state_d = BS_ISSUE;
        end
      end
      BS_ISSUE: begin
        if (issue) begin
          state_d = BS_WAIT;
        end
      end
      BS_WAIT: begin
        // Stay here as long as the bank stretches ack
        if (done) begin
          state_d = last_word ? BS_IDLE : BS_ISSUE;
        end
      end
      default: begin
        state_d = BS_IDLE;
      end
    endcase
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= BS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Command capture then address step and count down per word
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      op_q   <= OP_BURST_READ;
      addr_q <= '0;
      cnt_q  <= '0;
    end else if (start_ok) begin
      op_q   <= cmd_op_i;
      addr_q <= cmd_addr_i;
      // Zero count runs a single word
      cnt_q  <= (cmd_count_i == '0) ? CNT_ONE : cmd_count_i;
    end else if (done) begin
      addr_q <= addr_q + ADDR_ONE;
      cnt_q  <= cnt_q - CNT_ONE;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign busy_o      = (state_q != BS_IDLE);
  assign word_done_o = done;
  // Bridge holds read data stable once rdy is back
  assign rdata_o     = req.rdata;

  assign req.addr    = addr_q;
  // Write data sampled by the bridge in the strobe cycle
  assign req.wdata   = wdata_i;
  assign req.rd_wrn  = (op_q == OP_BURST_READ);
  assign req.strobe  = issue;

endmodule

//--- rtl/dbg_spr_ifs.sv
////////////////////////////////////////////////////////////////////////////
// dbg_req_if carries single word accesses in the tck domain
// spr_bus_if is the SPR bus in the cpu_clk domain
////////////////////////////////////////////////////////////////////////////

`include "dbg_spr_cfg.svh"

// Word access request from the burst controller to the bridge
interface dbg_req_if;
  logic [`DBG_ADDR_W-1:0] addr;
  logic [`DBG_DATA_W-1:0] wdata;
  // High for a read and low for a write
  logic                   rd_wrn;
  // One cycle pulse and only honoured while rdy is high
  logic                   strobe;
  logic [`DBG_DATA_W-1:0] rdata;
  logic                   rdy;

  modport master (output addr, wdata, rd_wrn, strobe, input rdata, rdy);
  modport slave (input addr, wdata, rd_wrn, strobe, output rdata, rdy);
endinterface

// SPR bus from the bridge to the register bank
interface spr_bus_if;
  logic [`DBG_ADDR_W-1:0] addr;
  logic [`DBG_DATA_W-1:0] wdata;
  logic                   we;
  // Held high until the ack cycle
  logic                   stb;
  // Valid during ack
  logic [`DBG_DATA_W-1:0] rdata;
  // Combinational from stb and may come in the first cycle
  logic                   ack;

  modport master (output addr, wdata, we, stb, input rdata, ack);
  modport slave (input addr, wdata, we, stb, output rdata, ack);
endinterface

//--- rtl/dbg_spr_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types for the debug SPR path
// Command opcodes and the FSM state encodings
////////////////////////////////////////////////////////////////////////////

package dbg_spr_pkg;

  // Burst command opcode
  typedef enum logic {
    OP_BURST_READ  = 1'b0,
    OP_BURST_WRITE = 1'b1
  } dbg_op_e;

  // Burst controller FSM in the tck domain
  typedef enum logic [1:0] {
    BS_IDLE  = 2'd0,
    BS_ISSUE = 2'd1,
    BS_WAIT  = 2'd2
  } burst_state_e;

  // CPU side FSM of the bridge
  // ST_TRANSFER only used by multi-cycle accesses
  typedef enum logic {
    ST_IDLE     = 1'b0,
    ST_TRANSFER = 1'b1
  } bridge_state_e;

endpackage

//--- rtl/dbg_spr_cfg.svh
////////////////////////////////////////////////////////////////////////////
// Width and depth macros for the debug SPR access path
////////////////////////////////////////////////////////////////////////////

`ifndef DBG_SPR_CFG_SVH
`define DBG_SPR_CFG_SVH

// SPR bus address width
`define DBG_ADDR_W 32

// SPR bus data width
`define DBG_DATA_W 32

// Words in the SPR bank
// Kept a power of two so the low address bits index it directly
`define SPR_DEPTH 16

// Width of the burst word count
// A count of zero runs as one word
`define BURST_CNT_W 8

`endif
